//--- tb.f
design/cpu_pkg.sv
design/ctrl_if.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/data_mem.sv
design/fetch.sv
design/cpu.sv
tb/clk_gen.sv
tb/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - design/cpu_pkg.sv
  - design/ctrl_if.sv
  - design/decoder.sv
  - design/reg_file.sv
  - design/alu.sv
  - design/data_mem.sv
  - design/fetch.sv
  - design/cpu.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_cpu.sv

//--- tb/tb_cpu.sv
module tb_cpu;

	localparam int n_random    = 2000;
	localparam int n_total     = 31 + cpu_pkg::dm_words + n_random;
	localparam int drain_limit = 16;

	typedef struct packed {
		logic        rf_we;
		logic [4:0]  rf_waddr;
		logic [31:0] rf_wdata;
		logic        dm_we;
		logic [31:0] dm_addr;
		logic [31:0] dm_wdata;
		logic [31:0] next_pc;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] pc;
	logic [31:0] instr;
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;
	logic        dm_we;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;

	// Instruction-set model state
	logic [31:0] model_regs [32];
	logic [31:0] model_mem  [64];
	logic [31:0] model_pc;
	logic [15:0] lfsr    = 16'd45;
	int          errors  = 0;
	int          checked = 0;

	clk_gen i_clk_gen (.clk(clk));

	cpu i_cpu (
		.clk      (clk),
		.rst_n    (rst_n),
		.pc       (pc),
		.instr    (instr),
		.rf_we    (rf_we),
		.rf_waddr (rf_waddr),
		.rf_wdata (rf_wdata),
		.dm_we    (dm_we),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata)
	);

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] make_r_type(input logic [4:0] rs, input logic [4:0] rt,
	                                            input logic [4:0] rd, input logic [5:0] funct);
		return {cpu_pkg::op_special, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] make_i_type(input logic [5:0] op, input logic [4:0] rs,
	                                            input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic random_instr(output logic [31:0] iw);
		logic [31:0] sel;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] rd;
		logic [31:0] imm;
		logic [31:0] extra;
		take_bits(4, sel);
		take_bits(5, rs);
		take_bits(5, rt);
		take_bits(5, rd);
		take_bits(16, imm);
		case (sel[3:0])
			4'd0: iw = make_r_type(rs[4:0], rt[4:0], rd[4:0], cpu_pkg::fn_addu);
			4'd1: iw = make_r_type(rs[4:0], rt[4:0], rd[4:0], cpu_pkg::fn_subu);
			4'd2: iw = make_r_type(rs[4:0], rt[4:0], rd[4:0], cpu_pkg::fn_and);
			4'd3: iw = make_r_type(rs[4:0], rt[4:0], rd[4:0], cpu_pkg::fn_or);
			4'd4: iw = make_r_type(rs[4:0], rt[4:0], rd[4:0], cpu_pkg::fn_slt);
			4'd5: iw = make_i_type(cpu_pkg::op_addiu, rs[4:0], rt[4:0], imm[15:0]);
			4'd6: iw = make_i_type(cpu_pkg::op_andi, rs[4:0], rt[4:0], imm[15:0]);
			4'd7: iw = make_i_type(cpu_pkg::op_ori, rs[4:0], rt[4:0], imm[15:0]);
			4'd8: iw = make_i_type(cpu_pkg::op_lui, 5'd0, rt[4:0], imm[15:0]);
			4'd9, 4'd14: begin
				take_bits(6, extra);
				iw = make_i_type(cpu_pkg::op_lw, 5'd0, rt[4:0], {8'h00, extra[5:0], 2'b00});
			end
			4'd10, 4'd15: begin
				take_bits(6, extra);
				iw = make_i_type(cpu_pkg::op_sw, 5'd0, rt[4:0], {8'h00, extra[5:0], 2'b00});
			end
			4'd11: iw = make_i_type(cpu_pkg::op_beq, rs[4:0], rt[4:0], imm[15:0]);
			4'd12: iw = make_i_type(cpu_pkg::op_bne, rs[4:0], rt[4:0], imm[15:0]);
			default: begin
				take_bits(26, extra);
				iw = {cpu_pkg::op_j, extra[25:0]};
			end
		endcase
	endtask

	// Expected outputs of one instruction against the model state
	function automatic expect_t predict(input logic [31:0] iw);
		expect_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] seq;
		logic [31:0] ea;
		a   = model_regs[iw[25:21]];
		b   = model_regs[iw[20:16]];
		sx  = {{16{iw[15]}}, iw[15:0]};
		zx  = {16'h0000, iw[15:0]};
		seq = model_pc + 32'd4;
		ea  = a + sx;
		e   = '0;
		e.next_pc  = seq;
		e.rf_waddr = iw[20:16];
		case (iw[31:26])
			cpu_pkg::op_special: begin
				e.rf_waddr = iw[15:11];
				e.rf_we    = 1'b1;
				case (iw[5:0])
					cpu_pkg::fn_addu: e.rf_wdata = a + b;
					cpu_pkg::fn_subu: e.rf_wdata = a - b;
					cpu_pkg::fn_and:  e.rf_wdata = a & b;
					cpu_pkg::fn_or:   e.rf_wdata = a | b;
					cpu_pkg::fn_slt:  e.rf_wdata = {31'd0, $signed(a) < $signed(b)};
					default:          e.rf_we    = 1'b0;
				endcase
			end
			cpu_pkg::op_addiu: {e.rf_we, e.rf_wdata} = {1'b1, a + sx};
			cpu_pkg::op_andi:  {e.rf_we, e.rf_wdata} = {1'b1, a & zx};
			cpu_pkg::op_ori:   {e.rf_we, e.rf_wdata} = {1'b1, a | zx};
			cpu_pkg::op_lui:   {e.rf_we, e.rf_wdata} = {1'b1, iw[15:0], 16'h0000};
			cpu_pkg::op_lw:    {e.rf_we, e.rf_wdata} = {1'b1, model_mem[ea[7:2]]};
			cpu_pkg::op_sw:    {e.dm_we, e.dm_addr, e.dm_wdata} = {1'b1, ea, b};
			cpu_pkg::op_beq:   e.next_pc = (a == b) ? seq + {sx[29:0], 2'b00} : seq;
			cpu_pkg::op_bne:   e.next_pc = (a != b) ? seq + {sx[29:0], 2'b00} : seq;
			cpu_pkg::op_j:     e.next_pc = {seq[31:28], iw[25:0], 2'b00};
			default: ;
		endcase
		return e;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expv,
	                               input logic [31:0] actv);
		errors++;
		$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expv, actv);
	endtask

	task automatic check_cycle();
		expect_t e;
		e = predict(instr);
		assert (pc === model_pc) else report_mismatch("pc", model_pc, pc);
		assert (rf_we === e.rf_we) else report_mismatch("rf_we", e.rf_we, rf_we);
		if (e.rf_we) begin
			assert (rf_waddr === e.rf_waddr) else
				report_mismatch("rf_waddr", e.rf_waddr, rf_waddr);
			assert (rf_wdata === e.rf_wdata) else
				report_mismatch("rf_wdata", e.rf_wdata, rf_wdata);
		end
		assert (dm_we === e.dm_we) else report_mismatch("dm_we", e.dm_we, dm_we);
		if (e.dm_we) begin
			assert (dm_addr === e.dm_addr) else report_mismatch("dm_addr", e.dm_addr, dm_addr);
			assert (dm_wdata === e.dm_wdata) else
				report_mismatch("dm_wdata", e.dm_wdata, dm_wdata);
		end
		// Retire into the model, register 0 stays zero
		if (e.rf_we && (e.rf_waddr != 5'd0)) begin
			model_regs[e.rf_waddr] = e.rf_wdata;
		end
		if (e.dm_we) begin
			model_mem[e.dm_addr[7:2]] = e.dm_wdata;
		end
		model_pc = e.next_pc;
		checked++;
	endtask

	// Outputs are stable since the falling edge
	initial begin : compare
		forever begin
			@(posedge clk);
			if (rst_n !== 1'b1) begin
				model_pc = '0;
				assert (rf_we === 1'b0) else report_mismatch("rf_we", 32'd0, rf_we);
				assert (dm_we === 1'b0) else report_mismatch("dm_we", 32'd0, dm_we);
			end else begin
				check_cycle();
			end
		end
	end

	task automatic apply_instr(input logic [31:0] iw);
		instr = iw;
		@(negedge clk);
	endtask

	initial begin : stimulus
		logic [31:0] word;
		logic [31:0] bits;
		int          waited;
		rst_n    = 1'b0;
		instr    = '0;
		model_pc = '0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		for (int w = 0; w < 64; w++) begin
			model_mem[w] = '0;
		end
		// Register and memory writes offered during reset must not retire
		for (int c = 0; c < 8; c++) begin
			if (c[0]) begin
				apply_instr(make_i_type(cpu_pkg::op_sw, 5'd0, 5'd0, 16'h0000));
			end else begin
				apply_instr(make_i_type(cpu_pkg::op_ori, 5'd0, 5'd1, 16'h00ff));
			end
		end
		rst_n = 1'b1;

		// Known value in every register, then in every memory word
		for (int r = 1; r < 32; r++) begin
			take_bits(16, bits);
			apply_instr(make_i_type(cpu_pkg::op_ori, 5'd0, r[4:0], bits[15:0]));
		end
		for (int w = 0; w < 64; w++) begin
			take_bits(5, bits);
			apply_instr(make_i_type(cpu_pkg::op_sw, 5'd0, bits[4:0], 16'(w * 4)));
		end
		for (int k = 0; k < n_random; k++) begin
			random_instr(word);
			apply_instr(word);
		end
		instr = '0;

		waited = 0;
		while ((checked < n_total) && (waited < drain_limit)) begin
			@(negedge clk);
			waited++;
		end
		if (checked < n_total) begin
			$display("Timeout: only %0d of %0d instructions were checked", checked, n_total);
			errors++;
		end
		$display("Instructions checked: %0d, errors: %0d", checked, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- tb/clk_gen.sv
module clk_gen (
	output logic clk
);

	// Period of 8, starting low
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

endmodule

//--- design/cpu.sv
module cpu (
	input  logic                           clk,
	input  logic                           rst_n,
	output logic [cpu_pkg::xlen-1:0]       pc,
	input  logic [cpu_pkg::xlen-1:0]       instr,
	output logic                           rf_we,
	output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
	output logic [cpu_pkg::xlen-1:0]       rf_wdata,
	output logic                           dm_we,
	output logic [cpu_pkg::xlen-1:0]       dm_addr,
	output logic [cpu_pkg::xlen-1:0]       dm_wdata
);

	cpu_pkg::instr_t          instr_dec;
	logic [cpu_pkg::xlen-1:0] rs_val;
	logic [cpu_pkg::xlen-1:0] rt_val;
	logic [cpu_pkg::xlen-1:0] alu_result;
	logic [cpu_pkg::xlen-1:0] dm_rdata;
	logic                     equal;

	assign instr_dec = instr;

	ctrl_if ctrl ();

	decoder i_decoder (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr_dec),
		.ctrl  (ctrl.src)
	);

	// Register read runs alongside decode on the same word
	reg_file i_reg_file (
		.clk    (clk),
		.raddr1 (instr_dec.r_fields.rs),
		.raddr2 (instr_dec.r_fields.rt),
		.waddr  (rf_waddr),
		.we     (rf_we),
		.wdata  (rf_wdata),
		.rdata1 (rs_val),
		.rdata2 (rt_val)
	);

	alu i_alu (
		.instr  (instr_dec),
		.ctrl   (ctrl.exe),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.result (alu_result),
		.equal  (equal)
	);

	data_mem i_data_mem (
		.clk   (clk),
		.addr  (dm_addr),
		.we    (dm_we),
		.wdata (dm_wdata),
		.rdata (dm_rdata)
	);

	fetch i_fetch (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr_dec),
		.ctrl  (ctrl.fetch),
		.equal (equal),
		.pc    (pc)
	);

	// Write-back select, using the wb group of the control word
	assign rf_we    = ctrl.rf_we;
	assign rf_waddr = ctrl.rf_dst_rd ? instr_dec.r_fields.rd : instr_dec.r_fields.rt;
	assign rf_wdata = ctrl.mem_to_reg ? dm_rdata : alu_result;

	// Store path, address straight from the adder
	assign dm_we    = ctrl.dm_we;
	assign dm_addr  = alu_result;
	assign dm_wdata = rt_val;

endmodule

//--- design/fetch.sv
module fetch (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cpu_pkg::instr_t          instr,
	ctrl_if.fetch                    ctrl,
	input  logic                     equal,
	output logic [cpu_pkg::xlen-1:0] pc
);

	logic [cpu_pkg::xlen-1:0] pc_plus4;
	logic [cpu_pkg::xlen-1:0] br_target;
	logic [cpu_pkg::xlen-1:0] j_target;
	logic [cpu_pkg::xlen-1:0] next_pc;
	logic [15:0]              br_off;
	logic                     taken;

	assign pc_plus4 = pc + 32'd4;
	assign br_off   = instr.i_fields.imm16;

	// Word offset relative to the delay-free pc+4
	assign br_target = pc_plus4 + {{(cpu_pkg::xlen-18){br_off[15]}}, br_off, 2'b00};
	assign j_target  = {pc_plus4[31:28], instr[25:0], 2'b00};

	// bne inverts the equality test
	assign taken = ctrl.is_branch && (equal ^ ctrl.branch_ne);

	assign next_pc = ctrl.is_jump ? j_target :
	                 taken        ? br_target : pc_plus4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

//--- design/data_mem.sv
module data_mem (
	input  logic                     clk,
	input  logic [cpu_pkg::xlen-1:0] addr,
	input  logic                     we,
	input  logic [cpu_pkg::xlen-1:0] wdata,
	output logic [cpu_pkg::xlen-1:0] rdata
);

	logic [cpu_pkg::xlen-1:0]      mem [cpu_pkg::dm_words];
	logic [cpu_pkg::dm_addr_w-1:0] word_idx;

	// Word index from the byte address, upper bits wrap
	assign word_idx = addr[cpu_pkg::dm_addr_w+1:2];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_idx] <= wdata;
		end
	end

	assign rdata = mem[word_idx];

	a_store_aligned: assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00));

endmodule

//--- design/alu.sv
module alu (
	input  cpu_pkg::instr_t           instr,
	ctrl_if.exe                       ctrl,
	input  logic [cpu_pkg::xlen-1:0]  rs_val,
	input  logic [cpu_pkg::xlen-1:0]  rt_val,
	output logic [cpu_pkg::xlen-1:0]  result,
	output logic                      equal
);

	logic [cpu_pkg::xlen-1:0] imm_ext;
	logic [cpu_pkg::xlen-1:0] op_b;
	logic [15:0]              imm16;

	assign imm16 = instr.i_fields.imm16;

	// Immediate extension
	always_comb begin
		case (ctrl.ext_mode)
			cpu_pkg::ext_sign: imm_ext = {{(cpu_pkg::xlen-16){imm16[15]}}, imm16};
			default:           imm_ext = {{(cpu_pkg::xlen-16){1'b0}}, imm16};
		endcase
	end

	assign op_b = ctrl.alu_src_imm ? imm_ext : rt_val;

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::alu_add: result = rs_val + op_b;
			cpu_pkg::alu_sub: result = rs_val - op_b;
			cpu_pkg::alu_and: result = rs_val & op_b;
			cpu_pkg::alu_or:  result = rs_val | op_b;
			// Signed compare, result is 0 or 1
			cpu_pkg::alu_slt: result = {{(cpu_pkg::xlen-1){1'b0}},
			                            $signed(rs_val) < $signed(op_b)};
			// Only the low half of op_b matters here
			cpu_pkg::alu_lui: result = {op_b[15:0], 16'h0000};
			default:          result = rs_val + op_b;
		endcase
	end

	// Branch compare always looks at the raw register values
	assign equal = (rs_val == rt_val);

endmodule

//--- design/reg_file.sv
module reg_file (
	input  logic                           clk,
	input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
	input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
	input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
	input  logic                           we,
	input  logic [cpu_pkg::xlen-1:0]       wdata,
	output logic [cpu_pkg::xlen-1:0]       rdata1,
	output logic [cpu_pkg::xlen-1:0]       rdata2
);

	logic [cpu_pkg::xlen-1:0] regs [1 << cpu_pkg::reg_addr_w];

	// Register 0 is never stored, so a write to it just drops
	always_ff @(posedge clk) begin
		if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// Combinational reads, $zero forced
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

//--- design/decoder.sv
module decoder (
	input  logic            clk,
	input  logic            rst_n,
	input  cpu_pkg::instr_t instr,
	ctrl_if.src             ctrl
);

	always_comb begin
		// Default is a no-op
		ctrl.alu_op      = cpu_pkg::alu_add;
		ctrl.ext_mode    = cpu_pkg::ext_sign;
		ctrl.alu_src_imm = 1'b0;
		ctrl.rf_we       = 1'b0;
		ctrl.rf_dst_rd   = 1'b0;
		ctrl.mem_to_reg  = 1'b0;
		ctrl.dm_we       = 1'b0;
		ctrl.is_branch   = 1'b0;
		ctrl.branch_ne   = 1'b0;
		ctrl.is_jump     = 1'b0;

		case (instr.r_fields.opcode)
			cpu_pkg::op_special: begin
				ctrl.rf_dst_rd = 1'b1;
				ctrl.rf_we     = 1'b1;
				case (instr.r_fields.funct)
					cpu_pkg::fn_addu: ctrl.alu_op = cpu_pkg::alu_add;
					cpu_pkg::fn_subu: ctrl.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::fn_and:  ctrl.alu_op = cpu_pkg::alu_and;
					cpu_pkg::fn_or:   ctrl.alu_op = cpu_pkg::alu_or;
					cpu_pkg::fn_slt:  ctrl.alu_op = cpu_pkg::alu_slt;
					// Unsupported function code retires as a no-op
					default:          ctrl.rf_we  = 1'b0;
				endcase
			end
			cpu_pkg::op_addiu: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.rf_we       = 1'b1;
			end
			cpu_pkg::op_andi, cpu_pkg::op_ori: begin
				ctrl.alu_op      = (instr.i_fields.opcode == cpu_pkg::op_andi) ?
				                   cpu_pkg::alu_and : cpu_pkg::alu_or;
				ctrl.ext_mode    = cpu_pkg::ext_zero;
				ctrl.alu_src_imm = 1'b1;
				ctrl.rf_we       = 1'b1;
			end
			cpu_pkg::op_lui: begin
				ctrl.alu_op      = cpu_pkg::alu_lui;
				ctrl.ext_mode    = cpu_pkg::ext_zero;
				ctrl.alu_src_imm = 1'b1;
				ctrl.rf_we       = 1'b1;
			end
			cpu_pkg::op_lw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.rf_we       = 1'b1;
			end
			cpu_pkg::op_sw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.dm_we       = 1'b1;
			end
			cpu_pkg::op_beq: ctrl.is_branch = 1'b1;
			cpu_pkg::op_bne: begin
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = 1'b1;
			end
			cpu_pkg::op_j: ctrl.is_jump = 1'b1;
			default: ;
		endcase

		// No state changes while in reset
		if (!rst_n) begin
			ctrl.rf_we = 1'b0;
			ctrl.dm_we = 1'b0;
		end
	end

	// A store and a register write can never retire in the same cycle
	a_we_exclusive: assert property (@(posedge clk) !(ctrl.rf_we && ctrl.dm_we));

endmodule

//--- design/ctrl_if.sv
interface ctrl_if;

	cpu_pkg::alu_op_t   alu_op;
	cpu_pkg::ext_mode_t ext_mode;
	logic               alu_src_imm;
	logic               rf_we;
	logic               rf_dst_rd;
	logic               mem_to_reg;
	logic               dm_we;
	logic               is_branch;
	logic               branch_ne;
	logic               is_jump;

	modport src (
		output alu_op, ext_mode, alu_src_imm, rf_we, rf_dst_rd,
		       mem_to_reg, dm_we, is_branch, branch_ne, is_jump
	);

	modport exe (input alu_op, ext_mode, alu_src_imm);

	modport fetch (input is_branch, branch_ne, is_jump);

	modport wb (input rf_we, rf_dst_rd, mem_to_reg, dm_we);

endinterface

//--- design/cpu_pkg.sv
package cpu_pkg;

	// Datapath and storage sizes
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int dm_words   = 64;
	localparam int dm_addr_w  = 6;

	// Primary opcodes, MIPS encoding
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_t;

	// Function codes under op_special
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	typedef enum logic [1:0] {
		ext_zero,
		ext_sign
	} ext_mode_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [reg_addr_w-1:0]  rs;
		logic [reg_addr_w-1:0]  rt;
		logic [reg_addr_w-1:0]  rd;
		logic [4:0]             shamt;
		funct_t                 funct;
	} r_fields_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [reg_addr_w-1:0]  rs;
		logic [reg_addr_w-1:0]  rt;
		logic [15:0]            imm16;
	} i_fields_t;

	// One instruction word seen either way; jump target is bits 25:0
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_t;

endpackage
